/* flist.f */
+incdir+hw
hw/rename_pkg.sv
hw/dispatch_ctrl.sv
hw/map_table.sv
hw/free_list.sv
hw/rob.sv
hw/rename_top.sv
dv/rename_chk.sv
dv/rename_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rename testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rename_tb -f flist.f -o rename_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/rename_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

/* dv/rename_tb.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_tb;

  import rename_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int TEST_CYCLES  = 600;
  localparam int DRAIN_CYCLES = 200;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + DRAIN_CYCLES;

  logic                clock;
  logic                rst_n;
  logic                dispatch_valid;
  arch_idx_t           dispatch_arch;
  logic                complete_en;
  rob_idx_t            complete_idx;
  logic                dispatch_ready;
  rob_idx_t            dispatch_rob_idx;
  preg_t               dispatch_preg;
  preg_t               dispatch_old_preg;
  logic                commit_en;
  logic                commit_wr_en;
  arch_idx_t           commit_arch;
  preg_t               commit_preg;
  logic [`COUNT_W-1:0] completed_insts;

  // Reference model
  preg_t              map_m [`NUM_ARCH];
  logic [`NUM_PR-1:0] free_m;
  rob_idx_t           pend_idx [$];    // Oldest at the front
  rob_entry_t         pend_entry [$];
  bit                 pend_done [$];
  rob_idx_t           tail_m;
  int                 retired_m;
  int                 errors;
  int                 checks;
  int                 cycle_cnt;

  rename_top UUT (
    .clock             (clock),
    .rst_n             (rst_n),
    .dispatch_valid    (dispatch_valid),
    .dispatch_arch     (dispatch_arch),
    .complete_en       (complete_en),
    .complete_idx      (complete_idx),
    .dispatch_ready    (dispatch_ready),
    .dispatch_rob_idx  (dispatch_rob_idx),
    .dispatch_preg     (dispatch_preg),
    .dispatch_old_preg (dispatch_old_preg),
    .commit_en         (commit_en),
    .commit_wr_en      (commit_wr_en),
    .commit_arch       (commit_arch),
    .commit_preg       (commit_preg),
    .completed_insts   (completed_insts)
  );

  bind rename_top rename_chk chk_0 (
    .clock            (clock),
    .rst_n            (rst_n),
    .push_en          (push_en),
    .dispatch_ready   (dispatch_ready),
    .dispatch_rob_idx (dispatch_rob_idx),
    .complete_en      (complete_en),
    .complete_idx     (complete_idx),
    .commit_en        (commit_en)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("sim failed");
    $finish;
  end

  function automatic preg_t lowest_free();
    for (int i = 0; i < `NUM_PR; i++) begin
      if (free_m[i]) begin
        return preg_t'(i);
      end
    end
    return '0;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("FAILED %s at %0t: expected %0d, actual %0d", name, $time, expected, actual);
    end
  endtask

  task automatic drive_inputs(input bit allow_dispatch);
    int open_slots [$];
    int pick;
    dispatch_valid = allow_dispatch && ($urandom_range(3) != 0);
    if ($urandom_range(9) < 2) begin
      dispatch_arch = arch_idx_t'(`ZERO_REG);  // About one in five
    end else begin
      dispatch_arch = arch_idx_t'($urandom_range(`ZERO_REG - 1));
    end
    for (int i = 0; i < pend_idx.size(); i++) begin
      if (!pend_done[i]) begin
        open_slots.push_back(i);
      end
    end
    complete_en  = 1'b0;
    complete_idx = '0;
    if (open_slots.size() != 0 && $urandom_range(1) == 1) begin
      pick         = open_slots[$urandom_range(open_slots.size() - 1)];
      complete_en  = 1'b1;
      complete_idx = pend_idx[pick];
    end
  endtask

  task automatic check_and_update();
    logic       has_dest;
    logic       exp_ready;
    logic       exp_commit;
    logic       fire;
    preg_t      new_preg;
    preg_t      old_m;
    rob_entry_t entry;
    has_dest   = dispatch_arch != arch_idx_t'(`ZERO_REG);
    exp_ready  = (pend_idx.size() < `NUM_ROB) && (!has_dest || free_m != '0);
    exp_commit = (pend_idx.size() != 0) && pend_done[0];
    fire       = dispatch_valid && exp_ready;
    new_preg   = has_dest ? lowest_free() : '0;
    old_m      = has_dest ? map_m[dispatch_arch] : '0;

    check_value("dispatch_ready", exp_ready, dispatch_ready);
    check_value("completed_insts", retired_m, completed_insts);
    check_value("commit_en", exp_commit, commit_en);
    check_value("commit_wr_en", exp_commit && pend_entry[0].has_dest, commit_wr_en);
    if (exp_commit) begin
      check_value("commit_arch", pend_entry[0].arch, commit_arch);
      check_value("commit_preg", pend_entry[0].preg, commit_preg);
    end
    if (fire) begin
      check_value("dispatch_rob_idx", tail_m, dispatch_rob_idx);
      check_value("dispatch_preg", new_preg, dispatch_preg);
      check_value("dispatch_old_preg", old_m, dispatch_old_preg);
    end

    // State after the coming edge
    if (exp_commit) begin
      if (pend_entry[0].has_dest) begin
        free_m[pend_entry[0].old_preg] = 1'b1;
      end
      void'(pend_idx.pop_front());
      void'(pend_entry.pop_front());
      void'(pend_done.pop_front());
      retired_m++;
    end
    if (fire) begin
      if (has_dest) begin
        free_m[new_preg]     = 1'b0;
        map_m[dispatch_arch] = new_preg;
      end
      entry.has_dest = has_dest;
      entry.arch     = dispatch_arch;
      entry.preg     = new_preg;
      entry.old_preg = old_m;
      pend_idx.push_back(tail_m);
      pend_entry.push_back(entry);
      pend_done.push_back(1'b0);
      tail_m = tail_m + rob_idx_t'(1);
    end
    if (complete_en) begin
      for (int i = 0; i < pend_idx.size(); i++) begin
        if (pend_idx[i] == complete_idx && !pend_done[i]) begin
          pend_done[i] = 1'b1;
        end
      end
    end
  endtask

  task automatic run_cycle(input bit allow_dispatch);
    @(posedge clock);
    #1;
    drive_inputs(allow_dispatch);
    @(negedge clock);  // Outputs settled
    check_and_update();
  endtask

  initial begin : main
    void'($urandom(32'h576b432e));
    rst_n          = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_arch  = '0;
    complete_en    = 1'b0;
    complete_idx   = '0;
    errors         = 0;
    checks         = 0;
    retired_m      = 0;
    tail_m         = '0;
    for (int i = 0; i < `NUM_ARCH; i++) begin
      map_m[i] = preg_t'(i);
    end
    for (int i = 0; i < `NUM_PR; i++) begin
      free_m[i] = (i >= `NUM_ARCH);
    end

    repeat (RESET_CYCLES) @(posedge clock);
    #1 rst_n = 1'b1;
    @(negedge clock);
    check_value("reset commit_en", 0, commit_en);
    check_value("reset completed_insts", 0, completed_insts);

    repeat (TEST_CYCLES) run_cycle(1'b1);
    while (pend_idx.size() != 0) begin
      run_cycle(1'b0);
    end
    run_cycle(1'b0);  // Last retire reaches the counter
    check_value("final completed_insts", retired_m, completed_insts);

    $display("Checks: %0d, errors: %0d, retired: %0d", checks, errors, retired_m);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* dv/rename_chk.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_chk (
  input                          clock,
  input                          rst_n,
  input                          push_en,
  input                          dispatch_ready,
  input  rename_pkg::rob_idx_t   dispatch_rob_idx,
  input                          complete_en,
  input  rename_pkg::rob_idx_t   complete_idx,
  input                          commit_en
);

  import rename_pkg::*;

  logic [`NUM_ROB-1:0] slot_valid;  // Occupied ROB slots
  rob_idx_t            head_ptr;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid <= '0;
      head_ptr   <= '0;
    end else begin
      if (commit_en) begin
        slot_valid[head_ptr] <= 1'b0;
        head_ptr             <= head_ptr + rob_idx_t'(1);
      end
      if (push_en) begin
        slot_valid[dispatch_rob_idx] <= 1'b1;
      end
    end
  end

  a_complete_live: assert property (@(posedge clock) disable iff (!rst_n)
    complete_en |-> slot_valid[complete_idx])
    else $error("completion names an empty ROB slot");

  // Stalled cycle leaves the ROB tail where it was
  a_push_gated: assert property (@(posedge clock) disable iff (!rst_n)
    !dispatch_ready |=> $stable(dispatch_rob_idx))
    else $error("ROB tail advanced while dispatch_ready was low");

endmodule

/* hw/rename_top.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_top (
  input                               clock,
  input                               rst_n,
  input                               dispatch_valid,
  input  rename_pkg::arch_idx_t       dispatch_arch,
  input                               complete_en,
  input  rename_pkg::rob_idx_t        complete_idx,
  output logic                        dispatch_ready,
  output rename_pkg::rob_idx_t        dispatch_rob_idx,
  output rename_pkg::preg_t           dispatch_preg,
  output rename_pkg::preg_t           dispatch_old_preg,
  output logic                        commit_en,
  output logic                        commit_wr_en,
  output rename_pkg::arch_idx_t       commit_arch,
  output rename_pkg::preg_t           commit_preg,
  output logic [`COUNT_W-1:0]         completed_insts
);

  import rename_pkg::*;

  logic       has_dest;
  logic       alloc_en;
  logic       push_en;
  logic       pop_en;
  logic       release_en;
  preg_t      release_preg;
  preg_t      alloc_preg;
  logic       free_empty;
  preg_t      old_preg;
  logic       rob_full;
  logic       head_done;
  rob_entry_t head_entry;
  rob_entry_t push_entry;

  // Zero register shows no mapping
  assign dispatch_preg     = has_dest ? alloc_preg : '0;
  assign dispatch_old_preg = has_dest ? old_preg : '0;

  assign push_entry = '{has_dest: has_dest, arch: dispatch_arch,
                        preg: dispatch_preg, old_preg: dispatch_old_preg};

  dispatch_ctrl dispatch_ctrl_0 (
    .clock           (clock),
    .rst_n           (rst_n),
    .dispatch_valid  (dispatch_valid),
    .dispatch_arch   (dispatch_arch),
    .free_empty      (free_empty),
    .rob_full        (rob_full),
    .head_done       (head_done),
    .head_entry      (head_entry),
    .dispatch_ready  (dispatch_ready),
    .alloc_en        (alloc_en),
    .push_en         (push_en),
    .has_dest        (has_dest),
    .pop_en          (pop_en),
    .release_en      (release_en),
    .release_preg    (release_preg),
    .commit_en       (commit_en),
    .commit_wr_en    (commit_wr_en),
    .commit_arch     (commit_arch),
    .commit_preg     (commit_preg),
    .completed_insts (completed_insts)
  );

  map_table map_table_0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .alloc_en      (alloc_en),
    .dispatch_arch (dispatch_arch),
    .alloc_preg    (alloc_preg),
    .old_preg      (old_preg)
  );

  free_list free_list_0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .alloc_en     (alloc_en),
    .release_en   (release_en),
    .release_preg (release_preg),
    .alloc_preg   (alloc_preg),
    .free_empty   (free_empty)
  );

  rob rob_0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .push_en      (push_en),
    .push_entry   (push_entry),
    .complete_en  (complete_en),
    .complete_idx (complete_idx),
    .pop_en       (pop_en),
    .full         (rob_full),
    .tail_idx     (dispatch_rob_idx),
    .head_done    (head_done),
    .head_entry   (head_entry)
  );

endmodule

/* hw/rob.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module rob (
  input                               clock,
  input                               rst_n,
  input                               push_en,
  input  rename_pkg::rob_entry_t      push_entry,
  input                               complete_en,
  input  rename_pkg::rob_idx_t        complete_idx,
  input                               pop_en,
  output logic                        full,
  output rename_pkg::rob_idx_t        tail_idx,
  output logic                        head_done,
  output rename_pkg::rob_entry_t      head_entry
);

  import rename_pkg::*;

  localparam int CNT_W = $clog2(`NUM_ROB + 1);

  rob_entry_t          entries [`NUM_ROB];
  logic [`NUM_ROB-1:0] done_q;
  rob_idx_t            head_q;
  rob_idx_t            tail_q;
  logic [CNT_W-1:0]    count_q;

  assign full       = count_q == CNT_W'(`NUM_ROB);
  assign tail_idx   = tail_q;
  assign head_entry = entries[head_q];
  assign head_done  = (count_q != '0) && done_q[head_q];

  // Payload only written at the tail
  always_ff @(posedge clock) begin
    if (push_en) begin
      entries[tail_q] <= push_entry;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= '0;
    end else begin
      if (complete_en) begin
        done_q[complete_idx] <= 1'b1;
      end
      if (push_en) begin
        done_q[tail_q] <= 1'b0;  // Fresh entry not yet complete
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_en) begin
        tail_q <= tail_q + rob_idx_t'(1);  // Wraps at NUM_ROB
      end
      if (pop_en) begin
        head_q <= head_q + rob_idx_t'(1);
      end
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* hw/free_list.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module free_list (
  input                               clock,
  input                               rst_n,
  input                               alloc_en,
  input                               release_en,
  input  rename_pkg::preg_t           release_preg,
  output rename_pkg::preg_t           alloc_preg,
  output logic                        free_empty
);

  import rename_pkg::*;

  logic [`NUM_PR-1:0] free_q;

  assign free_empty = ~|free_q;

  // Lowest free index wins
  always_comb begin
    alloc_preg = '0;
    for (int i = `NUM_PR - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        alloc_preg = preg_t'(i);
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_PR; i++) begin
        free_q[i] <= (i >= `NUM_ARCH);  // Arch regs hold the low pregs
      end
    end else begin
      if (alloc_en) begin
        free_q[alloc_preg] <= 1'b0;
      end
      // Released preg is in use, so never the one being allocated
      if (release_en) begin
        free_q[release_preg] <= 1'b1;
      end
    end
  end

endmodule

/* hw/map_table.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module map_table (
  input                               clock,
  input                               rst_n,
  input                               alloc_en,
  input  rename_pkg::arch_idx_t       dispatch_arch,
  input  rename_pkg::preg_t           alloc_preg,
  output rename_pkg::preg_t           old_preg
);

  import rename_pkg::*;

  preg_t map_q [`NUM_ARCH];

  // Current mapping, displaced on this dispatch
  assign old_preg = map_q[dispatch_arch];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_ARCH; i++) begin
        map_q[i] <= preg_t'(i);  // Identity
      end
    end else if (alloc_en) begin
      map_q[dispatch_arch] <= alloc_preg;
    end
  end

endmodule

/* hw/dispatch_ctrl.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module dispatch_ctrl (
  input                               clock,
  input                               rst_n,
  input                               dispatch_valid,
  input  rename_pkg::arch_idx_t       dispatch_arch,
  input                               free_empty,
  input                               rob_full,
  input                               head_done,
  input  rename_pkg::rob_entry_t      head_entry,
  output logic                        dispatch_ready,
  output logic                        alloc_en,
  output logic                        push_en,
  output logic                        has_dest,
  output logic                        pop_en,
  output logic                        release_en,
  output rename_pkg::preg_t           release_preg,
  output logic                        commit_en,
  output logic                        commit_wr_en,
  output rename_pkg::arch_idx_t       commit_arch,
  output rename_pkg::preg_t           commit_preg,
  output logic [`COUNT_W-1:0]         completed_insts
);

  import rename_pkg::*;

  assign has_dest       = dispatch_arch != arch_idx_t'(`ZERO_REG);
  // Zero register needs no free preg
  assign dispatch_ready = !rob_full && (!has_dest || !free_empty);
  assign push_en        = dispatch_valid && dispatch_ready;
  assign alloc_en       = push_en && has_dest;

  // Retire straight from the head
  assign commit_en    = head_done;
  assign pop_en       = head_done;
  assign commit_wr_en = head_done && head_entry.has_dest;
  assign release_en   = head_done && head_entry.has_dest;
  assign release_preg = head_entry.old_preg;
  assign commit_arch  = head_entry.arch;
  assign commit_preg  = head_entry.preg;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      completed_insts <= '0;
    end else if (pop_en) begin
      completed_insts <= completed_insts + 1'b1;
    end
  end

endmodule

/* hw/rename_pkg.sv */
`include "rename_settings.svh"

package rename_pkg;

  // Register and slot indices
  typedef logic [$clog2(`NUM_ARCH)-1:0] arch_idx_t;
  typedef logic [$clog2(`NUM_PR)-1:0]   preg_t;
  typedef logic [$clog2(`NUM_ROB)-1:0]  rob_idx_t;

  // One in-flight instruction
  typedef struct packed {
    logic      has_dest;  // Low for the zero register
    arch_idx_t arch;
    preg_t     preg;      // New mapping
    preg_t     old_preg;  // Mapping displaced at dispatch, freed at retire
  } rob_entry_t;

endpackage

/* hw/rename_settings.svh */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Register file sizes
`define NUM_ARCH 32
`define NUM_PR   40

`define NUM_ROB  16  // Larger than the free pool on purpose

`define ZERO_REG 31  // Never renamed, never written
`define COUNT_W  16

`endif
